/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 -Wno-fatal
TOP       ?= tb_max_pooler
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* filelist.f */
verilog/pool_pkg.sv
verilog/stream_fifo.sv
verilog/line_buffer.sv
verilog/window_max.sv
verilog/pool_sequencer.sv
verilog/max_pooler.sv
sim/tb_max_pooler.sv

/* sim/tb_max_pooler.sv */
`timescale 1ns/10ps

module tb_max_pooler;
    import pool_pkg::*;

    localparam int MAX_COLS   = 64;
    localparam int FIFO_DEPTH = 16;
    localparam int SEED       = 32'hfe7d;
    localparam int WAIT_LIMIT = 5000;
    localparam int NUM_CASES  = 7;

    // Pixel patterns
    localparam int PAT_RAMP   = 0;
    localparam int PAT_RANDOM = 1;
    localparam int PAT_CENTRE = 2;

    typedef struct {
        int rows;
        int cols;
        int pattern;
        int gap_pct;
        int stall_pct;
    } img_case_t;

    logic       clk;
    logic       rst;
    pool_cmd_t  cmd;
    logic       cmd_valid;
    logic       cmd_ready;
    pixel_t     in_data;
    logic       in_valid;
    logic       in_ready;
    pool_beat_t out_beat;
    logic       out_valid;
    logic       out_ready;
    logic       done;

    img_case_t  cases [NUM_CASES];
    pixel_t     img [1024];
    pool_beat_t exp_beats [$];
    int         done_count;

    max_pooler #(.MAX_COLS(MAX_COLS), .FIFO_DEPTH(FIFO_DEPTH)) DUT (
        .clk(clk), .rst(rst),
        .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
        .out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready),
        .done(done)
    );

    always #10 clk = ~clk;

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_beat(input string name, input pool_beat_t expected,
                              input pool_beat_t actual);
        if (actual !== expected) begin
            $display("ERR %0t %s expected data=%h last=%b actual data=%h last=%b", $time,
                     name, expected.data, expected.last, actual.data, actual.last);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // Every done pulse is counted, cmd_ready rises with it
    always @(negedge clk) begin
        if (rst) begin
            done_count <= 0;
        end else if (done) begin
            done_count <= done_count + 1;
            check_flag("cmd_ready", 1'b1, cmd_ready);
        end
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic pixel_t pool_ref(input img_case_t tc, input int r, input int c);
        pixel_t m;
        int     dr;
        int     dc;
        m = '0;
        if (r < 1 || r > tc.rows - 2 || c < 1 || c > tc.cols - 2) begin
            return '0;
        end
        for (dr = -1; dr <= 1; dr++) begin
            for (dc = -1; dc <= 1; dc++) begin
                if (img[(r + dr) * tc.cols + c + dc] > m) begin
                    m = img[(r + dr) * tc.cols + c + dc];
                end
            end
        end
        return m;
    endfunction

    task automatic build_image(input img_case_t tc);
        int         idx;
        pool_beat_t beat;
        exp_beats.delete();
        for (idx = 0; idx < tc.rows * tc.cols; idx++) begin
            case (tc.pattern)
                PAT_RAMP:   img[idx] = pixel_t'(idx * 37 + 5);
                PAT_CENTRE: img[idx] = (idx == (tc.rows / 2) * tc.cols + tc.cols / 2) ?
                                       16'hbeef : 16'h0000;
                // Saturated pixels now and then for the unsigned compare
                default:    img[idx] = (($urandom % 4) == 0) ? 16'hffff : pixel_t'($urandom);
            endcase
        end
        for (idx = 0; idx < tc.rows * tc.cols; idx++) begin
            beat.data = pool_ref(tc, idx / tc.cols, idx % tc.cols);
            beat.last = (idx == tc.rows * tc.cols - 1);
            exp_beats.push_back(beat);
        end
    endtask

    //////////////////////////////
    // Stream drivers
    //////////////////////////////

    task automatic send_command(input img_case_t tc);
        int idle;
        idle = 0;
        @(negedge clk);
        cmd.rows  = dim_t'(tc.rows);
        cmd.cols  = dim_t'(tc.cols);
        cmd_valid = 1'b1;
        while (!cmd_ready) begin
            @(negedge clk);
            idle++;
            if (idle > WAIT_LIMIT) begin
                report_failure("Command was never accepted, cmd_ready stayed low");
            end
        end
        @(negedge clk);
        cmd_valid = 1'b0;
        check_flag("cmd_ready", 1'b0, cmd_ready);
    endtask

    task automatic send_pixels(input img_case_t tc);
        int idx;
        int idle;
        idx  = 0;
        idle = 0;
        while (idx < tc.rows * tc.cols) begin
            @(negedge clk);
            idle++;
            if (($urandom % 100) < tc.gap_pct) begin
                in_valid = 1'b0;
            end else begin
                in_valid = 1'b1;
                in_data  = img[idx];
                // Transfer lands on the coming rising edge
                if (in_ready) begin
                    idx++;
                    idle = 0;
                end
            end
            if (idle > WAIT_LIMIT) begin
                report_failure($sformatf("Input stalled, pixel %0d was never accepted", idx));
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic collect_beats(input img_case_t tc);
        int k;
        int idle;
        k    = 0;
        idle = 0;
        while (k < exp_beats.size()) begin
            @(negedge clk);
            idle++;
            out_ready = (($urandom % 100) >= tc.stall_pct);
            if (out_ready && out_valid) begin
                check_beat($sformatf("out_beat[%0d]", k), exp_beats[k], out_beat);
                k++;
                idle = 0;
            end
            if (idle > WAIT_LIMIT) begin
                report_failure($sformatf("Output stalled, beat %0d never arrived", k));
            end
        end
        @(negedge clk);
        out_ready = 1'b0;
    endtask

    task automatic wait_for_done(input int target);
        int idle;
        idle = 0;
        while (done_count < target) begin
            @(negedge clk);
            idle++;
            if (idle > WAIT_LIMIT) begin
                report_failure("done never pulsed after the last beat");
            end
        end
    endtask

    task automatic load_cases();
        cases[0] = '{5, 5, PAT_RAMP, 0, 0};
        cases[1] = '{8, 12, PAT_RANDOM, 0, 0};
        cases[2] = '{3, 64, PAT_RANDOM, 0, 0};
        cases[3] = '{8, 12, PAT_RANDOM, 30, 50};
        cases[4] = '{3, 3, PAT_CENTRE, 0, 0};
        cases[5] = '{6, 20, PAT_RANDOM, 25, 70};
        cases[6] = '{4, 7, PAT_RANDOM, 50, 30};
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        cmd        = '0;
        cmd_valid  = 1'b0;
        in_data    = '0;
        in_valid   = 1'b0;
        out_ready  = 1'b0;
        void'($urandom(SEED));
        load_cases();

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_flag("cmd_ready", 1'b1, cmd_ready);
        check_flag("out_valid", 1'b0, out_valid);
        check_flag("in_ready", 1'b0, in_ready);
        check_flag("done", 1'b0, done);

        for (int n = 0; n < NUM_CASES; n++) begin
            build_image(cases[n]);
            send_command(cases[n]);
            fork
                send_pixels(cases[n]);
                collect_beats(cases[n]);
            join
            wait_for_done(n + 1);
            // A second pulse or a stray beat would show here
            repeat (4) @(negedge clk);
            if (done_count != n + 1) begin
                report_failure($sformatf("done pulsed %0d times for image %0d",
                                         done_count - n, n));
            end
            check_flag("out_valid", 1'b0, out_valid);
            check_flag("in_ready", 1'b0, in_ready);
            check_flag("cmd_ready", 1'b1, cmd_ready);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* verilog/line_buffer.sv */
`timescale 1ns/10ps

module line_buffer #(
    parameter int MAX_COLS = 64
) (
    input  logic                clk,
    input  logic                step_en,
    input  pool_pkg::pixel_t    step_pixel,
    input  pool_pkg::dim_t      step_col,
    input  pool_pkg::pool_tag_t step_tag,
    output pool_pkg::win_col_t  col_out,
    output pool_pkg::pool_tag_t col_tag
);
    import pool_pkg::*;

    localparam int AW = (MAX_COLS > 1) ? $clog2(MAX_COLS) : 1;

    //////////////////////////////
    // Row memories
    //////////////////////////////

    // Two rows back
    pixel_t row_old [MAX_COLS];
    // One row back
    pixel_t row_new [MAX_COLS];

    logic [AW-1:0] addr;
    pixel_t        old_px;
    pixel_t        new_px;

    assign addr   = AW'(step_col);
    assign old_px = row_old[addr];
    assign new_px = row_new[addr];

    // Newer row ages into the older one
    always_ff @(posedge clk) begin
        if (step_en) begin
            row_old[addr] <= new_px;
            row_new[addr] <= step_pixel;
        end
    end

    //////////////////////////////
    // Column register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (step_en) begin
            col_out.top <= old_px;
            col_out.mid <= new_px;
            col_out.bot <= step_pixel;
        end
    end

    // Tag lives for one cycle per step
    // so an idle cycle never repeats a result
    always_ff @(posedge clk) begin
        if (step_en) begin
            col_tag <= step_tag;
        end else begin
            col_tag <= '0;
        end
    end

endmodule

/* verilog/max_pooler.sv */
`timescale 1ns/10ps

module max_pooler #(
    parameter int MAX_COLS   = 64,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  pool_pkg::pool_cmd_t  cmd,
    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    input  pool_pkg::pixel_t     in_data,
    input  logic                 in_valid,
    output logic                 in_ready,
    output pool_pkg::pool_beat_t out_beat,
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic                 done
);
    import pool_pkg::*;

    pixel_t     in_head;
    logic       in_empty;
    logic       in_full;
    logic       in_pop;
    logic       in_accept;
    logic       accept_en;
    dim_t       out_free;
    logic       out_empty;
    pool_beat_t out_wr_beat;
    logic       last_beat;
    logic       step_en;
    pixel_t     step_pixel;
    dim_t       step_col;
    pool_tag_t  step_tag;
    win_col_t   lb_col;
    pool_tag_t  lb_tag;
    pixel_t     win_max;
    pool_tag_t  win_tag;

    assign in_ready  = accept_en && !in_full;
    assign in_accept = in_valid && in_ready;
    assign out_valid = !out_empty;

    // Border results become zero
    assign out_wr_beat.data = win_tag.keep ? win_max : '0;
    assign out_wr_beat.last = last_beat;

    stream_fifo #(.T(pixel_t), .FIFO_DEPTH(FIFO_DEPTH)) u_in_fifo (
        .clk(clk), .rst(rst),
        .wr_en(in_accept), .wr_data(in_data),
        .rd_en(in_pop), .rd_data(in_head),
        .empty(in_empty), .full(in_full), .free()
    );

    stream_fifo #(.T(pool_beat_t), .FIFO_DEPTH(FIFO_DEPTH)) u_out_fifo (
        .clk(clk), .rst(rst),
        .wr_en(win_tag.emit), .wr_data(out_wr_beat),
        .rd_en(out_valid && out_ready), .rd_data(out_beat),
        .empty(out_empty), .full(), .free(out_free)
    );

    pool_sequencer #(.MAX_COLS(MAX_COLS)) u_pool_sequencer (
        .clk(clk), .rst(rst),
        .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .in_accept(in_accept), .in_fifo_empty(in_empty), .in_fifo_data(in_head),
        .in_fifo_pop(in_pop), .accept_en(accept_en), .out_free(out_free),
        .step_en(step_en), .step_pixel(step_pixel), .step_col(step_col), .step_tag(step_tag),
        .beat_written(win_tag.emit), .last_beat(last_beat), .done(done)
    );

    line_buffer #(.MAX_COLS(MAX_COLS)) u_line_buffer (
        .clk(clk), .step_en(step_en), .step_pixel(step_pixel),
        .step_col(step_col), .step_tag(step_tag),
        .col_out(lb_col), .col_tag(lb_tag)
    );

    window_max u_window_max (
        .clk(clk), .rst(rst), .col_valid(step_en),
        .col_in(lb_col), .tag_in(lb_tag),
        .max_out(win_max), .tag_out(win_tag)
    );

endmodule

/* verilog/pool_pkg.sv */
package pool_pkg;

    //////////////////////////////
    // Widths and latencies
    //////////////////////////////

    // Pixel width in bits
    localparam int PIXEL_W = 16;

    // Width of image sizes and indices
    localparam int DIM_W = 10;

    // Column in to result out through the window
    localparam int WIN_LAT = 3;

    //////////////////////////////
    // Types
    //////////////////////////////

    typedef logic [PIXEL_W-1:0] pixel_t;

    typedef logic [DIM_W-1:0] dim_t;

    // Image size for one pooling job
    typedef struct packed {
        dim_t rows;
        dim_t cols;
    } pool_cmd_t;

    // Vertical slice of three rows, bot is the newest row
    typedef struct packed {
        pixel_t top;
        pixel_t mid;
        pixel_t bot;
    } win_col_t;

    // Sideband that follows a column down the pipe
    typedef struct packed {
        logic emit;
        logic keep;
    } pool_tag_t;

    // One beat of the result stream
    typedef struct packed {
        pixel_t data;
        logic   last;
    } pool_beat_t;

endpackage

/* verilog/pool_sequencer.sv */
`timescale 1ns/10ps

module pool_sequencer #(
    parameter int MAX_COLS = 64
) (
    input  logic                clk,
    input  logic                rst,
    input  pool_pkg::pool_cmd_t cmd,
    input  logic                cmd_valid,
    output logic                cmd_ready,
    input  logic                in_accept,
    input  logic                in_fifo_empty,
    input  pool_pkg::pixel_t    in_fifo_data,
    output logic                in_fifo_pop,
    output logic                accept_en,
    input  pool_pkg::dim_t      out_free,
    output logic                step_en,
    output pool_pkg::pixel_t    step_pixel,
    output pool_pkg::dim_t      step_col,
    output pool_pkg::pool_tag_t step_tag,
    input  logic                beat_written,
    output logic                last_beat,
    output logic                done
);
    import pool_pkg::*;

    localparam int CNT_W = 2 * DIM_W;

    typedef enum logic {ST_IDLE, ST_BUSY} state_t;

    state_t           state;
    dim_t             rows_r;
    dim_t             cols_r;
    logic [CNT_W-1:0] total_pix;
    logic [CNT_W-1:0] acc_cnt;
    logic [CNT_W-1:0] out_cnt;
    logic [DIM_W:0]   row_cnt;
    dim_t             col_cnt;
    dim_t             cen_row;
    dim_t             cen_col;
    logic             walk_done;
    logic             pix_phase;
    logic             have_data;
    logic             credit_ok;

    assign total_pix = rows_r * cols_r;
    assign cmd_ready = (state == ST_IDLE);
    assign accept_en = (state == ST_BUSY) && (acc_cnt != total_pix);

    //////////////////////////////
    // Step control
    //////////////////////////////

    // Rows past the image feed zero bubbles to drain the window
    assign pix_phase = (row_cnt < {1'b0, rows_r});
    assign have_data = !pix_phase || !in_fifo_empty;
    // Room for every result still in flight
    assign credit_ok = (out_free > dim_t'(WIN_LAT + 2));

    assign step_en     = (state == ST_BUSY) && !walk_done && have_data && credit_ok;
    assign in_fifo_pop = step_en && pix_phase;
    assign step_pixel  = pix_phase ? in_fifo_data : '0;
    assign step_col    = col_cnt;

    // Centre trails the step by one row and one column
    assign step_tag.emit = (row_cnt > 1) || ((row_cnt == 1) && (col_cnt != '0));
    assign step_tag.keep = (cen_row != '0) && (cen_row < rows_r - 1'b1) &&
                           (cen_col != '0) && (cen_col < cols_r - 1'b1);

    assign last_beat = (out_cnt == total_pix - 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            rows_r    <= '0;
            cols_r    <= '0;
            acc_cnt   <= '0;
            out_cnt   <= '0;
            row_cnt   <= '0;
            col_cnt   <= '0;
            cen_row   <= '0;
            cen_col   <= '0;
            walk_done <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (cmd_valid) begin
                        rows_r    <= cmd.rows;
                        // Row memories hold at most MAX_COLS pixels
                        cols_r    <= (cmd.cols > dim_t'(MAX_COLS)) ? dim_t'(MAX_COLS) : cmd.cols;
                        acc_cnt   <= '0;
                        out_cnt   <= '0;
                        row_cnt   <= '0;
                        col_cnt   <= '0;
                        cen_row   <= '0;
                        cen_col   <= '0;
                        walk_done <= 1'b0;
                        state     <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (in_accept) begin
                        acc_cnt <= acc_cnt + 1'b1;
                    end
                    if (step_en) begin
                        // Final step sits at the start of the second drain row
                        if (row_cnt == {1'b0, rows_r} + 1'b1) begin
                            walk_done <= 1'b1;
                        end
                        if (col_cnt == cols_r - 1'b1) begin
                            col_cnt <= '0;
                            row_cnt <= row_cnt + 1'b1;
                        end else begin
                            col_cnt <= col_cnt + 1'b1;
                        end
                        if (step_tag.emit) begin
                            if (cen_col == cols_r - 1'b1) begin
                                cen_col <= '0;
                                cen_row <= cen_row + 1'b1;
                            end else begin
                                cen_col <= cen_col + 1'b1;
                            end
                        end
                    end
                    if (beat_written) begin
                        out_cnt <= out_cnt + 1'b1;
                        if (last_beat) begin
                            done  <= 1'b1;
                            state <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

/* verilog/stream_fifo.sv */
`timescale 1ns/10ps

module stream_fifo #(
    parameter type T          = logic [15:0],
    parameter int  FIFO_DEPTH = 16
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           wr_en,
    input  T               wr_data,
    input  logic           rd_en,
    output T               rd_data,
    output logic           empty,
    output logic           full,
    output pool_pkg::dim_t free
);
    import pool_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    T                 mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // Pointer step with wrap for any depth
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign free  = dim_t'(FIFO_DEPTH) - dim_t'(count);

    // Head word shows before the pop
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* verilog/window_max.sv */
`timescale 1ns/10ps

module window_max (
    input  logic                clk,
    input  logic                rst,
    input  logic                col_valid,
    input  pool_pkg::win_col_t  col_in,
    input  pool_pkg::pool_tag_t tag_in,
    output pool_pkg::pixel_t    max_out,
    output pool_pkg::pool_tag_t tag_out
);
    import pool_pkg::*;

    // Older columns of the window, col_in is the newest
    win_col_t  col_d1;
    win_col_t  col_d2;

    // Stage 1 column maxima
    pixel_t    cm_new;
    pixel_t    cm_mid;
    pixel_t    cm_old;

    // Stage 2 partial result
    pixel_t    pair_max;
    pixel_t    old_max;

    pool_tag_t tag_pipe [WIN_LAT];

    function automatic pixel_t max2(input pixel_t a, input pixel_t b);
        return (a > b) ? a : b;
    endfunction

    function automatic pixel_t col_max(input win_col_t c);
        return max2(max2(c.top, c.mid), c.bot);
    endfunction

    // Shift happens on the step, the new column shows one cycle later
    always_ff @(posedge clk) begin
        if (col_valid) begin
            col_d1 <= col_in;
            col_d2 <= col_d1;
        end
    end

    //////////////////////////////
    // Max tree
    //////////////////////////////

    always_ff @(posedge clk) begin
        cm_new   <= col_max(col_in);
        cm_mid   <= col_max(col_d1);
        cm_old   <= col_max(col_d2);
        pair_max <= max2(cm_new, cm_mid);
        old_max  <= cm_old;
        max_out  <= max2(pair_max, old_max);
    end

    // Tag delay matches the tree depth
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < WIN_LAT; i++) begin
                tag_pipe[i] <= '0;
            end
        end else begin
            tag_pipe[0] <= tag_in;
            for (int i = 1; i < WIN_LAT; i++) begin
                tag_pipe[i] <= tag_pipe[i-1];
            end
        end
    end

    assign tag_out = tag_pipe[WIN_LAT-1];

endmodule
